// File: design/scratch_pkg.sv
// Shared widths, Wishbone request and response structs and enums for the scratchpad RAM
`default_nettype none

package scratch_pkg;

    // Word address width, the RAM holds 2**ADDR_W words
    localparam int ADDR_W = 6;

    // Data word width
    localparam int DATA_W = 32;

    // One Wishbone classic request as driven by a master
    // All fields stay stable from the rising of stb until the ack
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    // Wishbone response returned by the arbiter
    // Read data is only meaningful in the cycle where ack is high
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    // Names of the two bus ports
    // Also used as the tag of a read travelling through the read pipeline
    typedef enum logic {
        PORT_A = 1'b0,
        PORT_B = 1'b1
    } port_e;

    // Fill sequence state of the initialized RAM
    typedef enum logic {
        INIT_SWEEP = 1'b0,
        INIT_DONE  = 1'b1
    } init_state_e;

endpackage

`default_nettype wire

// File: design/sdp_ram.sv
// Simple dual-port RAM with registered read, optional output stages and write-to-read bypass
`timescale 1ns/10ps
`default_nettype none

module sdp_ram #(
    // Extra output register stages after the registered array read
    parameter int N_OUTPUT_REG_STAGES = 0,
    // Forward writes into reads that are still in the pipeline
    parameter int BYPASS_FULL_PIPELINE = 0
) (
    input  logic                           clk,

    input  logic                           wen,
    input  logic [scratch_pkg::ADDR_W-1:0] waddr,
    input  logic [scratch_pkg::DATA_W-1:0] wdata,

    input  logic [scratch_pkg::ADDR_W-1:0] raddr,
    output logic [scratch_pkg::DATA_W-1:0] rdata
);

    // Storage as a plain array, sized from the address width
    logic [scratch_pkg::DATA_W-1:0] mem [2**scratch_pkg::ADDR_W];

    // Read data pipeline
    // Index 0 is the registered array output, index N_OUTPUT_REG_STAGES is the last stage
    logic [scratch_pkg::DATA_W-1:0] rd_pipe [N_OUTPUT_REG_STAGES+1];

    // Data coming out of the last read stage, before any bypass
    logic [scratch_pkg::DATA_W-1:0] mem_rdata;

    // Write port and registered read port
    // Non-blocking update gives old data when both ports hit the same word
    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
        rd_pipe[0] <= mem[raddr];
    end

    generate
        if (N_OUTPUT_REG_STAGES > 0)
        begin : g_out_stages
            // Each extra stage simply delays the read data by one more cycle
            always_ff @(posedge clk)
            begin
                for (int s = 1; s <= N_OUTPUT_REG_STAGES; s++)
                begin
                    rd_pipe[s] <= rd_pipe[s-1];
                end
            end
        end
    endgenerate

    assign mem_rdata = rd_pipe[N_OUTPUT_REG_STAGES];

    generate
        if (BYPASS_FULL_PIPELINE == 0)
        begin : g_no_bypass
            // Reads see only the writes that finished before the read cycle
            assign rdata = mem_rdata;
        end
        else
        begin : g_bypass
            // One bypass slot travels next to each read stage
            // It holds the read address, whether a write hit it and the newest such write data
            typedef struct packed {
                logic [scratch_pkg::ADDR_W-1:0] addr;
                logic                           hit;
                logic [scratch_pkg::DATA_W-1:0] data;
            } byp_slot_t;

            byp_slot_t byp [N_OUTPUT_REG_STAGES+1];

            always_ff @(posedge clk)
            begin
                // A write in the read cycle itself is missed by the array read
                // so the first slot picks it up
                byp[0].addr <= raddr;
                byp[0].hit  <= wen && (waddr == raddr);
                byp[0].data <= wdata;

                // Later stages keep what they carry unless a newer write hits the
                // same address, in which case the newer data replaces it
                for (int s = 1; s <= N_OUTPUT_REG_STAGES; s++)
                begin
                    byp[s] <= byp[s-1];
                    if (wen && (waddr == byp[s-1].addr))
                    begin
                        byp[s].hit  <= 1'b1;
                        byp[s].data <= wdata;
                    end
                end
            end

            // Writes up to the cycle before the data returns are covered
            // A write in the return cycle itself is not forwarded
            always_comb
            begin
                if (byp[N_OUTPUT_REG_STAGES].hit)
                begin
                    rdata = byp[N_OUTPUT_REG_STAGES].data;
                end
                else
                begin
                    rdata = mem_rdata;
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: design/sdp_ram_init.sv
// Dual-port RAM wrapper that fills every word with a constant after reset, then raises rdy
`timescale 1ns/10ps
`default_nettype none

module sdp_ram_init #(
    parameter int                             N_OUTPUT_REG_STAGES = 0,
    parameter int                             BYPASS_FULL_PIPELINE = 0,
    parameter logic [scratch_pkg::DATA_W-1:0] INIT_VALUE = '0
) (
    input  logic                           clk,
    input  logic                           reset_n,

    input  logic                           wen,
    input  logic [scratch_pkg::ADDR_W-1:0] waddr,
    input  logic [scratch_pkg::DATA_W-1:0] wdata,

    input  logic [scratch_pkg::ADDR_W-1:0] raddr,
    output logic [scratch_pkg::DATA_W-1:0] rdata,

    // High once the fill is complete, stays high until the next reset
    output logic                           rdy
);

    scratch_pkg::init_state_e      state;
    logic [scratch_pkg::ADDR_W-1:0] sweep_addr;

    // Write port as seen by the RAM
    logic                           ram_wen;
    logic [scratch_pkg::ADDR_W-1:0] ram_waddr;
    logic [scratch_pkg::DATA_W-1:0] ram_wdata;

    // One word per cycle, starting at address 0 in the first cycle out of reset
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state      <= scratch_pkg::INIT_SWEEP;
            sweep_addr <= '0;
        end
        else if (state == scratch_pkg::INIT_SWEEP)
        begin
            sweep_addr <= sweep_addr + 1'b1;
            // The last word is written in this cycle
            if (sweep_addr == '1)
            begin
                state <= scratch_pkg::INIT_DONE;
            end
        end
    end

    assign rdy = (state == scratch_pkg::INIT_DONE);

    // The sweep owns the write port until the fill is complete
    assign ram_wen   = rdy ? wen   : 1'b1;
    assign ram_waddr = rdy ? waddr : sweep_addr;
    assign ram_wdata = rdy ? wdata : INIT_VALUE;

    sdp_ram #(
        .N_OUTPUT_REG_STAGES (N_OUTPUT_REG_STAGES),
        .BYPASS_FULL_PIPELINE(BYPASS_FULL_PIPELINE)
    ) ram (
        .clk  (clk),
        .wen  (ram_wen),
        .waddr(ram_waddr),
        .wdata(ram_wdata),
        .raddr(raddr),
        .rdata(rdata)
    );

    // Once raised, rdy must hold until a reset is applied
    rdy_sticky: assert property (@(posedge clk) disable iff (!reset_n)
        $past(reset_n) && $past(rdy) |-> rdy)
        else $error("rdy fell without reset");

endmodule

`default_nettype wire

// File: design/wb_ram_arbiter.sv
// Two-port Wishbone classic front end that shares the RAM write and read ports between masters
`timescale 1ns/10ps
`default_nettype none

module wb_ram_arbiter #(
    // Read latency of the RAM is one plus this value
    parameter int N_OUTPUT_REG_STAGES = 0
) (
    input  logic                           clk,
    input  logic                           reset_n,

    input  scratch_pkg::wb_req_t           port_a_req,
    input  scratch_pkg::wb_req_t           port_b_req,
    output scratch_pkg::wb_rsp_t           port_a_rsp,
    output scratch_pkg::wb_rsp_t           port_b_rsp,

    // RAM side
    input  logic                           rdy,
    output logic                           wen,
    output logic [scratch_pkg::ADDR_W-1:0] waddr,
    output logic [scratch_pkg::DATA_W-1:0] wdata,
    output logic [scratch_pkg::ADDR_W-1:0] raddr,
    input  logic [scratch_pkg::DATA_W-1:0] rdata
);

    localparam int L = 1 + N_OUTPUT_REG_STAGES;

    // One read in flight and the port that asked for it
    typedef struct packed {
        logic               vld;
        scratch_pkg::port_e tag;
    } rd_slot_t;

    // Requests indexed by port so both ports share the same logic
    scratch_pkg::wb_req_t req [2];

    logic [1:0] busy;
    logic [1:0] want_w;
    logic [1:0] want_r;
    logic [1:0] wgrant;
    logic [1:0] rgrant;
    logic [1:0] wack;
    logic [1:0] rack;
    logic [1:0] ack;
    logic       conflict;

    scratch_pkg::port_e rr_ptr;
    rd_slot_t           rd_pipe [L];

    assign req[0] = port_a_req;
    assign req[1] = port_b_req;

    always_comb
    begin
        // A port may only issue once per request, and nothing issues during the fill
        for (int p = 0; p < 2; p++)
        begin
            want_w[p] = rdy && req[p].cyc && req[p].stb && !busy[p] && req[p].we;
            want_r[p] = rdy && req[p].cyc && req[p].stb && !busy[p] && !req[p].we;
        end

        // Each RAM port goes to the only asker, or to the pointer's port on a tie
        for (int p = 0; p < 2; p++)
        begin
            wgrant[p] = want_w[p] &&
                        (!want_w[1-p] || (rr_ptr == scratch_pkg::port_e'(p)));
            rgrant[p] = want_r[p] &&
                        (!want_r[1-p] || (rr_ptr == scratch_pkg::port_e'(p)));
        end
    end

    // Both ports wanting the same RAM port is the only case that moves the pointer
    assign conflict = (&want_w) || (&want_r);

    // RAM port muxes, a read and a write from different ports go out together
    assign wen   = |wgrant;
    assign waddr = wgrant[1] ? req[1].adr : req[0].adr;
    assign wdata = wgrant[1] ? req[1].dat : req[0].dat;
    assign raddr = rgrant[1] ? req[1].adr : req[0].adr;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            busy   <= '0;
            wack   <= '0;
            rr_ptr <= scratch_pkg::PORT_A;
            for (int s = 0; s < L; s++)
            begin
                rd_pipe[s] <= '0;
            end
        end
        else
        begin
            // Busy covers the time from issue up to and including the ack cycle
            busy <= (busy & ~ack) | wgrant | rgrant;

            // The write lands in the array at the end of the issue cycle
            wack <= wgrant;

            if (conflict)
            begin
                rr_ptr <= (rr_ptr == scratch_pkg::PORT_A) ? scratch_pkg::PORT_B :
                                                            scratch_pkg::PORT_A;
            end

            // Reads march alongside the RAM pipeline, several may be in flight
            rd_pipe[0].vld <= |rgrant;
            rd_pipe[0].tag <= rgrant[1] ? scratch_pkg::PORT_B : scratch_pkg::PORT_A;
            for (int s = 1; s < L; s++)
            begin
                rd_pipe[s] <= rd_pipe[s-1];
            end
        end
    end

    // The read at the end of the pipeline meets its data on rdata in this cycle
    always_comb
    begin
        for (int p = 0; p < 2; p++)
        begin
            rack[p] = rd_pipe[L-1].vld && (rd_pipe[L-1].tag == scratch_pkg::port_e'(p));
        end
    end

    assign ack = wack | rack;

    assign port_a_rsp = '{ack: ack[0], dat: rdata};
    assign port_b_rsp = '{ack: ack[1], dat: rdata};

    generate
        for (genvar p = 0; p < 2; p++)
        begin : g_port_chk
            // The master holds its request until the ack, so the ack must find it there
            ack_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
                ack[p] |-> req[p].cyc && req[p].stb)
                else $error("ack on port %0d without an active request", p);

            // A port has at most one request issued, so its two ack sources never meet
            one_ack_kind: assert property (@(posedge clk) disable iff (!reset_n)
                !(wack[p] && rack[p]))
                else $error("read and write ack together on port %0d", p);
        end
    endgenerate

    // Nothing may reach the RAM write port while the fill still owns it
    wen_after_rdy: assert property (@(posedge clk) disable iff (!reset_n)
        wen |-> rdy)
        else $error("write issued before the RAM was ready");

endmodule

`default_nettype wire

// File: design/scratch_ram_top.sv
// Top level of the shared scratchpad, two Wishbone ports in front of one initialized RAM
`timescale 1ns/10ps
`default_nettype none

module scratch_ram_top #(
    parameter int                             N_OUTPUT_REG_STAGES = 0,
    parameter int                             BYPASS_FULL_PIPELINE = 1,
    parameter logic [scratch_pkg::DATA_W-1:0] INIT_VALUE = '0
) (
    input  logic                 clk,
    input  logic                 reset_n,

    input  scratch_pkg::wb_req_t port_a_req,
    input  scratch_pkg::wb_req_t port_b_req,
    output scratch_pkg::wb_rsp_t port_a_rsp,
    output scratch_pkg::wb_rsp_t port_b_rsp
);

    // Arbiter to RAM wiring
    logic                           ram_wen;
    logic [scratch_pkg::ADDR_W-1:0] ram_waddr;
    logic [scratch_pkg::DATA_W-1:0] ram_wdata;
    logic [scratch_pkg::ADDR_W-1:0] ram_raddr;
    logic [scratch_pkg::DATA_W-1:0] ram_rdata;
    logic                           ram_rdy;

    // Both masters are served here, the arbiter holds off all traffic until rdy
    wb_ram_arbiter #(
        .N_OUTPUT_REG_STAGES(N_OUTPUT_REG_STAGES)
    ) arb (
        .clk       (clk),
        .reset_n   (reset_n),
        .port_a_req(port_a_req),
        .port_b_req(port_b_req),
        .port_a_rsp(port_a_rsp),
        .port_b_rsp(port_b_rsp),
        .rdy       (ram_rdy),
        .wen       (ram_wen),
        .waddr     (ram_waddr),
        .wdata     (ram_wdata),
        .raddr     (ram_raddr),
        .rdata     (ram_rdata)
    );

    // Storage with the fill sequence in front of its write port
    sdp_ram_init #(
        .N_OUTPUT_REG_STAGES (N_OUTPUT_REG_STAGES),
        .BYPASS_FULL_PIPELINE(BYPASS_FULL_PIPELINE),
        .INIT_VALUE          (INIT_VALUE)
    ) ram (
        .clk    (clk),
        .reset_n(reset_n),
        .wen    (ram_wen),
        .waddr  (ram_waddr),
        .wdata  (ram_wdata),
        .raddr  (ram_raddr),
        .rdata  (ram_rdata),
        .rdy    (ram_rdy)
    );

endmodule

`default_nettype wire

// File: tests/scratch_ram_tb.sv
// Self-checking testbench for the scratchpad, drives both Wishbone ports and checks with assertions
`timescale 1ns/10ps
`default_nettype none

module scratch_ram_tb;

    localparam int N_STAGES = 2;
    localparam int LAT = 1 + N_STAGES;
    localparam logic [scratch_pkg::DATA_W-1:0] INIT_VAL = 32'h5a5a_0000;

    // Transactions planned per phase
    localparam int N_INIT_RD = 8;
    localparam int N_PAIRS   = 8;
    localparam int N_XPORT   = 8;
    localparam int N_BYP     = 4;
    localparam int N_BURST   = 16;
    localparam int N_TRANS   = N_INIT_RD + 2 * N_PAIRS + 2 * N_XPORT + 3 * N_BYP + 4 * N_BURST;
    localparam int CYCLE_LIMIT = 64 + 8 * N_TRANS;

    logic clk = 1'b0;
    logic reset_n;

    scratch_pkg::wb_req_t req [2];
    scratch_pkg::wb_rsp_t rsp [2];

    // Reference memory, updated at each write ack
    logic [scratch_pkg::DATA_W-1:0] model [2**scratch_pkg::ADDR_W];
    logic [scratch_pkg::DATA_W-1:0] exp_dat [2];

    int   hold_cnt [2];
    int   sent [2];
    int   acked [2];
    int   since_rst;
    int   cycles;
    int   last_ack;
    logic exact_timing;
    logic alt_check;

    always #5 clk = ~clk;

    scratch_ram_top #(
        .N_OUTPUT_REG_STAGES (N_STAGES),
        .BYPASS_FULL_PIPELINE(1),
        .INIT_VALUE          (INIT_VAL)
    ) dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .port_a_req(req[0]),
        .port_b_req(req[1]),
        .port_a_rsp(rsp[0]),
        .port_b_rsp(rsp[1])
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    function automatic logic [scratch_pkg::ADDR_W-1:0] random_addr();
        logic [31:0] rnd;
        rnd = $urandom();
        return rnd[scratch_pkg::ADDR_W-1:0];
    endfunction

    // Called right after a rising edge, returns right after the edge that ends the ack cycle
    task automatic xfer(input int p, input logic we,
                        input logic [scratch_pkg::ADDR_W-1:0] adr,
                        input logic [scratch_pkg::DATA_W-1:0] dat);
        req[p] <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        sent[p] = sent[p] + 1;
        // Ack is looked at mid-cycle where it is settled
        @(negedge clk);
        while (!rsp[p].ack)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        req[p] <= '0;
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(3)) @(posedge clk);
    endtask

    // Expected read data is the model plus a write acked in this same cycle
    always_comb
    begin
        for (int p = 0; p < 2; p++)
        begin
            exp_dat[p] = model[req[p].adr];
            for (int q = 0; q < 2; q++)
            begin
                if (rsp[q].ack && req[q].we && (req[q].adr == req[p].adr))
                begin
                    exp_dat[p] = req[q].dat;
                end
            end
        end
    end

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int a = 0; a < 2**scratch_pkg::ADDR_W; a++)
            begin
                model[a] <= INIT_VAL;
            end
            since_rst <= 0;
        end
        else
        begin
            // At most one write is acked per cycle, so the order here never matters
            for (int q = 0; q < 2; q++)
            begin
                if (rsp[q].ack && req[q].we)
                begin
                    model[req[q].adr] <= req[q].dat;
                end
            end
            since_rst <= since_rst + 1;
        end
    end

    always @(posedge clk)
    begin
        for (int p = 0; p < 2; p++)
        begin
            // Cycles the current request has been on the bus, 0 in its first cycle
            if (!(req[p].cyc && req[p].stb) || rsp[p].ack)
            begin
                hold_cnt[p] <= 0;
            end
            else
            begin
                hold_cnt[p] <= hold_cnt[p] + 1;
            end
            if (rsp[p].ack)
            begin
                acked[p] <= acked[p] + 1;
            end
        end
        // Remembers which port got the last ack during a burst, 2 means none yet
        if (!alt_check)
        begin
            last_ack <= 2;
        end
        else if (rsp[0].ack)
        begin
            last_ack <= 0;
        end
        else if (rsp[1].ack)
        begin
            last_ack <= 1;
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            abort_run($sformatf("timeout after %0d cycles, a request never got its ack", cycles));
        end
    end

    generate
        for (genvar g = 0; g < 2; g++)
        begin : g_chk
            rd_data_ok: assert property (@(posedge clk) disable iff (!reset_n)
                rsp[g].ack && !req[g].we |-> rsp[g].dat == exp_dat[g])
                else abort_run($sformatf("error %0t: port %0d read of word %0d gave %h, expected %h",
                    $time, g, $sampled(req[g].adr), $sampled(rsp[g].dat), $sampled(exp_dat[g])));

            ack_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
                rsp[g].ack |-> req[g].cyc && req[g].stb)
                else abort_run($sformatf("port %0d was acked while it had no request", g));

            one_ack_only: assert property (@(posedge clk) disable iff (!reset_n)
                rsp[g].ack |=> !rsp[g].ack)
                else abort_run($sformatf("port %0d was acked twice for one request", g));

            // The fill takes one cycle per word, so no ack can come before it ends
            no_early_ack: assert property (@(posedge clk) disable iff (!reset_n)
                rsp[g].ack |-> since_rst > 2**scratch_pkg::ADDR_W)
                else abort_run($sformatf("port %0d was acked before the fill could finish", g));

            wr_latency: assert property (@(posedge clk) disable iff (!reset_n)
                exact_timing && rsp[g].ack && req[g].we |-> hold_cnt[g] == 1)
                else abort_run($sformatf("error %0t: port %0d write acked after %0d cycles",
                    $time, g, $sampled(hold_cnt[g])));

            rd_latency: assert property (@(posedge clk) disable iff (!reset_n)
                exact_timing && rsp[g].ack && !req[g].we |-> hold_cnt[g] == LAT)
                else abort_run($sformatf("error %0t: port %0d read acked after %0d cycles",
                    $time, g, $sampled(hold_cnt[g])));

            ack_alternates: assert property (@(posedge clk) disable iff (!reset_n)
                alt_check && rsp[g].ack |-> last_ack != g)
                else abort_run($sformatf("port %0d was acked twice in a row in a burst", g));
        end
    endgenerate

    initial
    begin
        int                             p;
        logic [scratch_pkg::ADDR_W-1:0] adr;
        logic [scratch_pkg::DATA_W-1:0] dat;

        void'($urandom(32'ha4e5));
        reset_n      <= 1'b0;
        req[0]       <= '0;
        req[1]       <= '0;
        exact_timing <= 1'b0;
        alt_check    <= 1'b0;
        cycles       <= 0;
        sent[0]       = 0;
        sent[1]       = 0;
        acked[0]     <= 0;
        acked[1]     <= 0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;

        // Reads of untouched words, the first one waits through the fill
        xfer(0, 1'b0, random_addr(), '0);
        exact_timing <= 1'b1;
        for (int i = 1; i < N_INIT_RD; i++)
        begin
            idle_gap();
            xfer($urandom_range(1), 1'b0, random_addr(), '0);
        end

        // Write then read back on the same port
        for (int i = 0; i < N_PAIRS; i++)
        begin
            p   = $urandom_range(1);
            adr = random_addr();
            dat = $urandom();
            idle_gap();
            xfer(p, 1'b1, adr, dat);
            xfer(p, 1'b0, adr, '0);
        end

        // Write on one port and read on the other
        for (int i = 0; i < N_XPORT; i++)
        begin
            adr = random_addr();
            dat = $urandom();
            xfer(i % 2, 1'b1, adr, dat);
            idle_gap();
            xfer(1 - (i % 2), 1'b0, adr, '0);
        end
        exact_timing <= 1'b0;

        // Port B writes the word that port A is reading, at each offset into the read latency
        for (int d = 0; d < N_BYP; d++)
        begin
            adr = random_addr();
            xfer(0, 1'b1, adr, $urandom());
            fork
                xfer(0, 1'b0, adr, '0);
                begin
                    repeat (d) @(posedge clk);
                    xfer(1, 1'b1, adr, $urandom());
                end
            join
        end

        // Back-to-back writes from both ports, then back-to-back reads
        alt_check <= 1'b1;
        fork
            for (int i = 0; i < N_BURST; i++)
            begin
                xfer(0, 1'b1, random_addr(), $urandom());
            end
            for (int i = 0; i < N_BURST; i++)
            begin
                xfer(1, 1'b1, random_addr(), $urandom());
            end
        join
        alt_check <= 1'b0;
        @(posedge clk);
        alt_check <= 1'b1;
        fork
            for (int i = 0; i < N_BURST; i++)
            begin
                xfer(0, 1'b0, random_addr(), '0);
            end
            for (int i = 0; i < N_BURST; i++)
            begin
                xfer(1, 1'b0, random_addr(), '0);
            end
        join
        alt_check <= 1'b0;

        @(negedge clk);
        if ((acked[0] != sent[0]) || (acked[1] != sent[1]))
        begin
            abort_run($sformatf("ack count differs from request count, sent %0d/%0d acked %0d/%0d",
                sent[0], sent[1], acked[0], acked[1]));
        end
        else
        begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: compile.f
design/scratch_pkg.sv
design/sdp_ram.sv
design/sdp_ram_init.sv
design/wb_ram_arbiter.sv
design/scratch_ram_top.sv
tests/scratch_ram_tb.sv

// File: Makefile
# Verilator build and run for the scratchpad RAM testbench

VERILATOR   ?= verilator
TOP         ?= scratch_ram_tb
FILELIST    ?= compile.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --binary --timing --assert -j 0
EXTRA_FLAGS ?=
SIM_ARGS    ?=

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exits with a failing status when the testbench stops on a failed check
run: compile
	$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
